// File: common/exec_pkg.sv
`default_nettype none

package exec_pkg;

	localparam int data_width = 32;	// Operand and result width

	// Bits handled per multiply/divide cycle (1, 2 or 4)
	localparam int muldiv_steps_default = 1;

	typedef enum logic [4:0] {
		op_and   = 5'd0,	// Bitwise and
		op_or    = 5'd1,
		op_xor   = 5'd2,
		op_addu  = 5'd3,
		op_subu  = 5'd4,
		op_sltu  = 5'd5,	// Set less than, unsigned
		op_slt   = 5'd6,	// Set less than, signed
		op_multu = 5'd7,
		op_mult  = 5'd8,
		op_sll   = 5'd9,	// Shift amount from immediate
		op_sllv  = 5'd10,	// Shift amount from b[4:0]
		op_sra   = 5'd11,
		op_srl   = 5'd12,
		op_srav  = 5'd13,
		op_srlv  = 5'd14,
		op_lui   = 5'd15,
		op_div   = 5'd16,
		op_divu  = 5'd17,
		op_mfhi  = 5'd18,	// Read HI
		op_mflo  = 5'd19,	// Read LO
		op_beq   = 5'd20,
		op_bne   = 5'd21,
		op_bgez  = 5'd22,
		op_bgtz  = 5'd23,
		op_blez  = 5'd24,
		op_bltz  = 5'd25
	} exec_op_t;

	// Immediate field as the decoder hands it over
	typedef struct packed {
		logic [15:0] ext;	// Sign extension of the immediate
		logic [4:0]  rd;
		logic [4:0]  shamt;	// Bits 10:6
		logic [5:0]  funct;
	} imm_field_t;

	typedef union packed {
		logic [data_width-1:0] raw;	// Plain data word
		imm_field_t            imm;	// Immediate field view
	} operand_word_t;

	typedef enum logic [1:0] {
		class_alu    = 2'd0,
		class_branch = 2'd1,
		class_muldiv = 2'd2,	// Goes to the iterative unit
		class_move   = 2'd3	// MFHI and MFLO
	} op_class_t;

endpackage

`default_nettype wire

// File: alu/alu_core.sv
`timescale 1ns/10ps
`default_nettype none

module alu_core import exec_pkg::*; (
	input  exec_op_t              op,
	input  logic [data_width-1:0] a,
	input  operand_word_t         b,
	output logic [data_width-1:0] y,
	output logic                  zero
);

	logic [4:0] shamt_imm;	// Fixed shift amount
	logic [4:0] shamt_var;	// Variable shift amount
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt_imm = b.imm.shamt;
	assign shamt_var = b.raw[4:0];

	assign lt_signed   = $signed(a) < $signed(b.raw);
	assign lt_unsigned = a < b.raw;

	always_comb begin
		y = '0;
		case (op)
			op_and: begin
				y = a & b.raw;
			end
			op_or: begin
				y = a | b.raw;
			end
			op_xor: begin
				y = a ^ b.raw;
			end
			op_addu: begin
				y = a + b.raw;	// No overflow trap
			end
			op_subu: begin
				y = a - b.raw;
			end
			op_sltu: begin
				y = {{(data_width-1){1'b0}}, lt_unsigned};
			end
			op_slt: begin
				y = {{(data_width-1){1'b0}}, lt_signed};
			end
			op_sll: begin
				y = a << shamt_imm;
			end
			op_sllv: begin
				y = a << shamt_var;
			end
			op_sra: begin
				y = $signed(a) >>> shamt_imm;	// Sign bit copied in
			end
			op_srl: begin
				y = a >> shamt_imm;
			end
			op_srav: begin
				y = $signed(a) >>> shamt_var;
			end
			op_srlv: begin
				y = a >> shamt_var;
			end
			op_lui: begin
				y = {b.raw[15:0], 16'h0000};	// Immediate into upper half
			end
			default: begin
				y = '0;	// Branches, moves and muldiv
			end
		endcase
	end

	assign zero = (y == '0);

endmodule

`default_nettype wire

// File: alu/branch_compare.sv
`timescale 1ns/10ps
`default_nettype none

module branch_compare import exec_pkg::*; (
	input  exec_op_t              op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	output logic                  taken
);

	logic a_neg;
	logic a_zero;
	logic a_eq_b;

	assign a_neg  = a[data_width-1];	// Signed compare against zero
	assign a_zero = (a == '0);
	assign a_eq_b = (a == b);

	always_comb begin
		case (op)
			op_beq:  taken = a_eq_b;
			op_bne:  taken = !a_eq_b;
			op_bgez: taken = !a_neg;
			op_bgtz: taken = !a_neg && !a_zero;
			op_blez: taken = a_neg || a_zero;
			op_bltz: taken = a_neg;
			default: taken = 1'b0;	// Not a branch
		endcase
	end

endmodule

`default_nettype wire

// File: muldiv/mult_div_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mult_div_unit import exec_pkg::*; #(
	parameter int muldiv_steps = muldiv_steps_default
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  exec_op_t              op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	output logic                  busy,
	output logic [data_width-1:0] hi,
	output logic [data_width-1:0] lo
);

	localparam int         iterations = data_width / muldiv_steps;
	localparam logic [5:0] last_count = 6'(iterations);

	logic                    signed_op;
	logic                    div_op;
	logic [data_width-1:0]   a_abs;
	logic [data_width-1:0]   b_abs;
	logic [5:0]              count;	// Iterations done
	logic                    is_div;
	logic                    neg_q;	// Negate product or quotient
	logic                    neg_r;	// Negate remainder
	logic [data_width-1:0]   operand_b;	// Multiplicand or divisor
	logic [2*data_width-1:0] acc;	// {upper, lower} working pair
	logic [2*data_width-1:0] acc_next;
	logic [data_width:0]     sum;
	logic [data_width+1:0]   rem_trial;
	logic [2*data_width-1:0] prod_out;
	logic [data_width-1:0]   rem_out;
	logic [data_width-1:0]   quo_out;

	assign signed_op = (op == op_mult) || (op == op_div);
	assign div_op    = (op == op_div) || (op == op_divu);

	assign a_abs = (signed_op && a[data_width-1]) ? -a : a;
	assign b_abs = (signed_op && b[data_width-1]) ? -b : b;

	// One cycle worth of shift-add or restoring divide steps
	always_comb begin
		acc_next  = acc;
		sum       = '0;
		rem_trial = '0;
		for (int i = 0; i < muldiv_steps; i++) begin
			if (is_div) begin
				rem_trial = {1'b0, acc_next[2*data_width-1:data_width-1]} - {2'b00, operand_b};
				if (!rem_trial[data_width+1]) begin
					acc_next = {rem_trial[data_width-1:0], acc_next[data_width-2:0], 1'b1};
				end else begin
					acc_next = {acc_next[2*data_width-2:0], 1'b0};	// Restore
				end
			end else begin
				sum = {1'b0, acc_next[2*data_width-1:data_width]} +
					(acc_next[0] ? {1'b0, operand_b} : '0);
				acc_next = {sum, acc_next[data_width-1:1]};
			end
		end
	end

	// Sign correction for the last cycle
	assign prod_out = neg_q ? -acc : acc;
	assign rem_out  = neg_r ? -acc[2*data_width-1:data_width] : acc[2*data_width-1:data_width];
	assign quo_out  = neg_q ? -acc[data_width-1:0] : acc[data_width-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= '0;
			hi    <= '0;
			lo    <= '0;
		end else if (start) begin
			busy  <= 1'b1;
			count <= '0;
		end else if (busy) begin
			if (count != last_count) begin
				count <= count + 6'd1;
			end else begin
				busy <= 1'b0;
				if (is_div) begin
					hi <= rem_out;	// Remainder in HI
					lo <= quo_out;
				end else begin
					hi <= prod_out[2*data_width-1:data_width];
					lo <= prod_out[data_width-1:0];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			acc       <= {{data_width{1'b0}}, a_abs};
			operand_b <= b_abs;
			is_div    <= div_op;
			// Divide by zero keeps the all ones quotient
			neg_q     <= signed_op && (a[data_width-1] ^ b[data_width-1]) &&
				!(div_op && (b == '0));
			neg_r     <= signed_op && div_op && a[data_width-1];
		end else if (busy && (count != last_count)) begin
			acc <= acc_next;
		end
	end

endmodule

`default_nettype wire

// File: design/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage import exec_pkg::*; #(
	parameter int muldiv_steps = muldiv_steps_default
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  exec_op_t              op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	output logic                  result_valid,
	output logic [data_width-1:0] result,
	output logic                  zero,
	output logic                  branch_taken
);

	op_class_t             op_class;
	logic                  accept;
	logic                  start;
	logic                  load;	// Result produced next cycle
	logic                  busy;
	logic                  taken;
	logic [data_width-1:0] alu_y;
	logic                  alu_zero;
	logic [data_width-1:0] hi;
	logic [data_width-1:0] lo;
	logic [data_width-1:0] move_val;
	logic [data_width-1:0] result_next;
	logic                  zero_next;

	always_comb begin
		case (op)
			op_mult, op_multu, op_div, op_divu: op_class = class_muldiv;
			op_mfhi, op_mflo:                   op_class = class_move;
			op_beq, op_bne, op_bgez,
			op_bgtz, op_blez, op_bltz:          op_class = class_branch;
			default:                            op_class = class_alu;
		endcase
	end

	// Whole stage stalls while a multiply or divide runs
	assign in_ready = !busy;
	assign accept   = in_valid && in_ready;
	assign start    = accept && (op_class == class_muldiv);
	assign load     = accept && (op_class != class_muldiv);

	alu_core u_alu (
		.op   (op),
		.a    (a),
		.b    (b),
		.y    (alu_y),
		.zero (alu_zero)
	);

	branch_compare u_branch (
		.op    (op),
		.a     (a),
		.b     (b),
		.taken (taken)
	);

	mult_div_unit #(
		.muldiv_steps (muldiv_steps)
	) u_muldiv (
		.clk   (clk),
		.reset (reset),
		.start (start),
		.op    (op),
		.a     (a),
		.b     (b),
		.busy  (busy),
		.hi    (hi),
		.lo    (lo)
	);

	assign move_val    = (op == op_mfhi) ? hi : lo;
	assign result_next = (op_class == class_move) ? move_val : alu_y;
	assign zero_next   = (op_class == class_move) ? (move_val == '0) : alu_zero;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			branch_taken <= 1'b0;
		end else begin
			result_valid <= load;
			if (load) begin
				branch_taken <= taken;	// Zero for non-branch ops
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			result <= result_next;
			zero   <= zero_next;
		end
	end

endmodule

`default_nettype wire

// File: verification/exec_ref.svh
`ifndef exec_ref_svh
`define exec_ref_svh

// Class from the encoding ranges with branches at 20 and above
function automatic op_class_t ref_class(input exec_op_t op);
	if (op >= op_beq) begin
		return class_branch;
	end else if (op == op_mfhi || op == op_mflo) begin
		return class_move;
	end else if (op == op_mult || op == op_multu || op == op_div || op == op_divu) begin
		return class_muldiv;
	end
	return class_alu;
endfunction

function automatic logic [31:0] ref_alu(input exec_op_t op, input logic [31:0] a,
		input logic [31:0] b);
	logic [4:0]  sh;
	logic [31:0] fill;	// Sign bits brought in by an arithmetic shift
	sh = (op == op_sll || op == op_srl || op == op_sra) ? b[10:6] : b[4:0];
	fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
	case (op)
		op_and: return a & b;
		op_or: return a | b;
		op_xor: return a ^ b;
		op_addu: return a + b;
		op_subu: return a - b;
		op_sltu: return {31'h0, a < b};
		op_slt: return {31'h0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};	// Offset binary
		op_sll, op_sllv: return a << sh;
		op_srl, op_srlv: return a >> sh;
		op_sra, op_srav: return (a >> sh) | fill;
		op_lui: return {b[15:0], 16'h0};
		default: return 32'h0;
	endcase
endfunction

function automatic logic ref_taken(input exec_op_t op, input logic [31:0] a,
		input logic [31:0] b);
	case (op)
		op_beq: return a == b;
		op_bne: return a != b;
		op_bgez: return $signed(a) >= 0;
		op_bgtz: return $signed(a) > 0;
		op_blez: return $signed(a) <= 0;
		op_bltz: return $signed(a) < 0;
		default: return 1'b0;
	endcase
endfunction

// Gives {hi, lo} with the quotient truncated toward zero
function automatic logic [63:0] ref_muldiv(input exec_op_t op, input logic [31:0] a,
		input logic [31:0] b);
	longint sa;
	longint sb;
	longint q;
	longint r;
	sa = longint'($signed(a));
	sb = longint'($signed(b));
	if (op == op_multu) begin
		return {32'h0, a} * {32'h0, b};
	end else if (op == op_mult) begin
		return sa * sb;
	end else if (b == 32'h0) begin
		return {a, 32'hffff_ffff};	// Divide by zero
	end else if (op == op_divu) begin
		return {a % b, a / b};
	end
	q = sa / sb;
	r = sa % sb;	// Sign of the dividend
	return {r[31:0], q[31:0]};
endfunction

function automatic logic [31:0] ref_result(input exec_op_t op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] hi, input logic [31:0] lo);
	case (ref_class(op))
		class_move: return (op == op_mfhi) ? hi : lo;
		class_alu: return ref_alu(op, a, b);
		default: return 32'h0;	// ALU output is zero for branches
	endcase
endfunction

`endif

// File: verification/exec_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage_tb import exec_pkg::*; ();

	localparam int steps       = muldiv_steps_default;
	localparam int busy_cycles = data_width / steps + 1;	// Iterations plus sign fix

	typedef struct {
		exec_op_t              op;
		logic [data_width-1:0] result;
		logic                  zero;
		logic                  taken;
		int                    due;	// Cycle with result_valid expected
	} expect_t;

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	logic                  in_ready;
	exec_op_t              op;
	logic [data_width-1:0] a;
	logic [data_width-1:0] b;
	logic                  result_valid;
	logic [data_width-1:0] result;
	logic                  zero;
	logic                  branch_taken;

	expect_t               exp_q[$];
	logic [63:0]           hilo_q[$];	// {hi, lo} per multiply or divide
	expect_t               head;
	logic [63:0]           hilo_head;
	logic [data_width-1:0] model_hi;
	logic [data_width-1:0] model_lo;
	int                    cycle;
	int                    issued;
	int                    stall_len;
	exec_op_t              shift_ops [6] = '{op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav};

	`include "exec_ref.svh"

	exec_stage #(
		.muldiv_steps (steps)
	) uut (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.op           (op),
		.a            (a),
		.b            (b),
		.result_valid (result_valid),
		.result       (result),
		.zero         (zero),
		.branch_taken (branch_taken)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	task automatic abort_run(input string reason);
		$display("TEST FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_result(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
			abort_run("result mismatch");
		end
	endtask

	task automatic check_flag(input logic got, input logic expected, input string what);
		if (got !== expected) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, what, got, expected);
			abort_run("flag mismatch");
		end
	endtask

	task automatic check_hilo(input logic [31:0] got_hi, input logic [31:0] got_lo,
			input logic [31:0] exp_hi, input logic [31:0] exp_lo);
		if (got_hi !== exp_hi || got_lo !== exp_lo) begin
			$display("ERROR at %0t: HI/LO is %h/%h, expected %h/%h", $time,
				got_hi, got_lo, exp_hi, exp_lo);
			abort_run("HI/LO mismatch");
		end
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic issue(input exec_op_t op_i, input logic [31:0] a_i, input logic [31:0] b_i);
		expect_t     e;
		logic [63:0] hl;
		in_valid = 1'b1;
		op = op_i;
		a = a_i;
		b = b_i;
		issued++;
		while (in_ready !== 1'b1) begin
			@(negedge clk);
		end
		if (ref_class(op_i) == class_muldiv) begin
			hl = ref_muldiv(op_i, a_i, b_i);
			{model_hi, model_lo} = hl;
			hilo_q.push_back(hl);
		end else begin
			e.op = op_i;
			e.result = ref_result(op_i, a_i, b_i, model_hi, model_lo);
			e.zero = (e.result == 32'h0);
			e.taken = ref_taken(op_i, a_i, b_i);
			e.due = cycle + 1;
			exp_q.push_back(e);
		end
		@(negedge clk);
	endtask

	task automatic idle(input int n);
		in_valid = 1'b0;
		op = exec_op_t'(5'($urandom_range(25, 0)));	// Junk while not valid
		repeat (n) begin
			@(negedge clk);
		end
	endtask

	task automatic alu_sweep();
		exec_op_t    opv;
		logic [31:0] x;
		for (int k = 0; k < 26; k++) begin
			opv = exec_op_t'(5'(k));
			if (ref_class(opv) == class_alu) begin
				for (int n = 0; n < 8; n++) begin
					issue(opv, $urandom, $urandom);
					if ($urandom_range(3, 0) == 0) begin
						idle(1);
					end
				end
				x = $urandom;
				issue(opv, x, x);
			end
		end
	endtask

	task automatic shift_sweep();
		foreach (shift_ops[s]) begin
			for (int n = 0; n < 12; n++) begin
				issue(shift_ops[s], $urandom, $urandom);
			end
			issue(shift_ops[s], 32'h8000_0000, 32'hffff_ffff);	// Both amounts 31
			issue(shift_ops[s], 32'h8765_4321, 32'hffff_f83f);	// shamt 0, variable 31
			issue(shift_ops[s], 32'hf000_000f, 32'h0000_07c0);	// shamt 31, variable 0
		end
	endtask

	task automatic branch_sweep();
		exec_op_t    opv;
		logic [31:0] x;
		for (int k = 0; k < 6; k++) begin
			opv = exec_op_t'(5'(op_beq + k));
			x = $urandom;
			issue(opv, x, x);
			issue(opv, x, x ^ (32'h1 << $urandom_range(31, 0)));
			issue(opv, $urandom | 32'h8000_0000, $urandom);
			issue(opv, 32'h0, $urandom);
			issue(opv, ($urandom & 32'h7fff_ffff) | 32'h1, $urandom);
			issue(opv, 32'h0, 32'h0);
		end
	endtask

	// Each multiply or divide is read back through MFHI and MFLO
	task automatic muldiv_sweep();
		exec_op_t    opv;
		logic [31:0] x;
		logic [31:0] y;
		for (int m = 0; m < 4; m++) begin
			opv = (m == 0) ? op_mult : (m == 1) ? op_multu : (m == 2) ? op_div : op_divu;
			for (int n = 0; n < 10; n++) begin
				x = $urandom;
				y = $urandom;
				case (n)
					0: {x, y} = {32'h8000_0000, 32'h8000_0000};
					1: {x, y} = {32'hffff_ffff, 32'hffff_ffff};
					2: {x, y} = {32'h8000_0000, 32'hffff_ffff};
					3: {x, y} = {32'hffff_ff9c, 32'h0000_0007};	// -100 and 7
					4: {x, y} = {32'h0000_0064, 32'hffff_fff9};
					5: {x, y} = {32'hffff_ff9c, 32'hffff_fff9};
					6: y = 32'h0;
					7: {x, y} = {32'h8000_0000, 32'h0000_0000};
					8: y = y >> 20;
					default: y = y | 32'h1;
				endcase
				issue(opv, x, y);
				issue(op_mfhi, $urandom, $urandom);
				issue(op_mflo, $urandom, $urandom);
			end
		end
	endtask

	// in_valid never drops, so ops queue up behind a busy unit
	task automatic mixed_stream();
		for (int n = 0; n < 60; n++) begin
			issue(exec_op_t'(5'($urandom_range(25, 0))), $urandom, $urandom);
		end
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle > issued * 34 + 200) begin
			$display("Run timed out after %0d cycles with %0d operations issued", cycle, issued);
			abort_run("timeout");
		end
	end

	always @(negedge clk) begin
		if (!reset && result_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("result_valid high in cycle %0d with no operation outstanding", cycle);
				abort_run("unexpected result");
			end else begin
				head = exp_q.pop_front();
				if (head.due != cycle) begin
					$display("%s result came in cycle %0d instead of %0d", head.op.name(),
						cycle, head.due);
					abort_run("result timing");
				end else begin
					check_result(result, head.result, $sformatf("%s result", head.op.name()));
					check_flag(zero, head.zero, $sformatf("%s zero", head.op.name()));
					check_flag(branch_taken, head.taken, $sformatf("%s taken", head.op.name()));
				end
			end
		end else if (!reset && exp_q.size() != 0 && exp_q[0].due <= cycle) begin
			$display("%s result missing in cycle %0d", exp_q[0].op.name(), cycle);
			abort_run("lost result");
		end
	end

	// Stall length and HI/LO when the unit lets go of in_ready
	always @(negedge clk) begin
		if (!reset && in_ready === 1'b0) begin
			stall_len = stall_len + 1;
		end else if (!reset && stall_len != 0) begin
			if (stall_len != busy_cycles) begin
				$display("in_ready was low %0d cycles, expected %0d", stall_len, busy_cycles);
				abort_run("stall length");
			end else if (hilo_q.size() == 0) begin
				$display("in_ready dropped with no multiply or divide issued");
				abort_run("unexpected stall");
			end else begin
				hilo_head = hilo_q.pop_front();
				check_hilo(uut.hi, uut.lo, hilo_head[63:32], hilo_head[31:0]);
				stall_len = 0;
			end
		end
	end

	initial begin
		void'($urandom(32'h258a3493));
		reset = 1'b1;
		in_valid = 1'b0;
		op = op_and;
		a = '0;
		b = '0;
		model_hi = '0;
		model_lo = '0;
		repeat (10) begin
			@(negedge clk);
		end
		check_flag(result_valid, 1'b0, "result_valid after reset");
		check_flag(branch_taken, 1'b0, "branch_taken after reset");
		check_flag(in_ready, 1'b1, "in_ready after reset");
		check_hilo(uut.hi, uut.lo, 32'h0, 32'h0);
		reset = 1'b0;
		alu_sweep();
		shift_sweep();
		branch_sweep();
		muldiv_sweep();
		mixed_stream();
		idle(1);
		for (int k = 0; k < 2 * busy_cycles && (exp_q.size() != 0 || hilo_q.size() != 0); k++) begin
			@(negedge clk);
		end
		repeat (4) begin
			@(negedge clk);
		end
		if (exp_q.size() == 0 && hilo_q.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("%0d results and %0d HI/LO updates never arrived", exp_q.size(),
				hilo_q.size());
			abort_run("operations outstanding");
		end
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+verification
common/exec_pkg.sv
alu/alu_core.sv
alu/branch_compare.sv
muldiv/mult_div_unit.sv
design/exec_stage.sv
verification/exec_stage_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := exec_stage_tb
FILELIST := list.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verification/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
